//--- run_sim.sh
#!/bin/sh
# Build the operand fetch testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=operand_fetch_sim
LOG=sim_run.log

verilator --binary --timing -f src.f --top-module operand_fetch_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation executable returned status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0

//--- sim/operand_fetch_stimulus.txt
# W addr vec | X addr (random vec) | I (idle) | vectors are hex, w first and x last
# R name addr op swz const expected | B name addr op swz const wvec expected (write and read)
I
I
I
W 0 44444444333333332222222211111111
W 1 dddd0004cccc0003bbbb0002aaaa0001
W 2 800000037fffffff00000001deadbeef
W 3 0a0b0c0d01020304f0f0f0f012345678
X 5
X 6
W 9 99990003999900029999000199990000
I
R id_r0 0 0 e4 0000 44444444333333332222222211111111
I
I
R wzyx_r0 0 0 1b 0000 11111111222222223333333344444444
R xxxx_r1 1 0 00 0000 aaaa0001aaaa0001aaaa0001aaaa0001
R wwww_r2 2 0 ff 0000 80000003800000038000000380000003
R yzxw_r3 3 0 c9 0000 0a0b0c0d1234567801020304f0f0f0f0
R id_r2 2 0 e4 0000 800000037fffffff00000001deadbeef
R int_sel_no_mod_r1 1 1 e4 1234 dddd0004cccc0003bbbb0002aaaa0001
I
R mod_int_r5 5 3 e4 1abc 00001abc00001abc00001abc00001abc
R mod_int_max_r6 6 3 1b 1fff 00001fff00001fff00001fff00001fff
R mod_flt_r5 5 2 e4 1abc 3c0000003c0000003c0000003c000000
R mod_flt_r6 6 2 00 007f 7f0000007f0000007f0000007f000000
R mod_flt_hi_r0 0 2 c9 0080 00000000000000000000000000000000
I
I
R b2b_r0 0 0 e4 0000 44444444333333332222222211111111
R b2b_r1 1 0 1b 0000 aaaa0001bbbb0002cccc0003dddd0004
R b2b_r2 2 0 00 0000 deadbeefdeadbeefdeadbeefdeadbeef
R b2b_r3 3 0 e4 0000 0a0b0c0d01020304f0f0f0f012345678
I
B wr_rd_same_r9 9 0 e4 0000 aaaaaaaabbbbbbbbccccccccdddddddd 99990003999900029999000199990000
R after_wr_r9 9 0 e4 0000 aaaaaaaabbbbbbbbccccccccdddddddd
I
I

//--- sim/operand_fetch_tb.sv
// Operand fetch testbench
// Replays write, read and idle records from the stimulus file, keeps a
// register model to cross-check each expected operand, and compares
// the DUT source operand against the expected value of every read
`timescale 1ns/1ns

module operand_fetch_tb
  import shader_isa_pkg::*, shader_data_pkg::*;
();

  localparam int MAX_RECS     = 64;
  localparam int READ_LATENCY = 2;

  typedef logic [8*24-1:0] name_t;

  // ==================================================
  // DUT and clock
  // ==================================================
  logic       clk;
  logic       reset;
  logic       wr_en;
  reg_addr_t  wr_addr;
  vec4_t      wr_data;
  logic       rd_en;
  reg_addr_t  rd_addr;
  src_op_t    src_op;
  swz4d_t     swz;
  src_const_t src_const;
  logic       src_valid;
  vec4_t      src_data;

  tb_clock_gen u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  operand_fetch dut (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .src_op    (src_op),
    .swz       (swz),
    .src_const (src_const),
    .src_valid (src_valid),
    .src_data  (src_data)
  );

  // ==================================================
  // Records, model and scoreboard state
  // ==================================================
  logic [7:0] rec_kind  [MAX_RECS];
  name_t      rec_name  [MAX_RECS];
  reg_addr_t  rec_addr  [MAX_RECS];
  src_op_t    rec_op    [MAX_RECS];
  swz4d_t     rec_swz   [MAX_RECS];
  src_const_t rec_cnst  [MAX_RECS];
  vec4_t      rec_wdata [MAX_RECS];
  vec4_t      rec_exp   [MAX_RECS];
  int         num_recs;

  // Register contents as the write records leave them
  vec4_t model_regs [NUM_REGS];

  // Reads in flight, oldest first
  name_t pend_name  [$];
  vec4_t pend_exp   [$];
  int    pend_cycle [$];

  int    rand_seed;
  int    tick;
  int    cycle_cnt = 0;
  int    timeout_cycles = 0;
  int    pass_cnt;
  int    fail_cnt;
  int    err_cnt;
  logic  first_out_seen;
  logic  reset_bad;
  vec4_t reset_bad_val;

  // Expected operand from the swizzle, or the constant on all four components
  function automatic vec4_t predict_operand(input vec4_t v, input src_op_t op,
                                            input swz4d_t sw, input src_const_t k);
    vec4_t  res;
    dword_t fill;
    int     c;
    int     sel;
    res = '0;
    if (op[SRCOP_MOD_BIT]) begin
      if (op[SRCOP_INT_BIT]) begin
        fill = {{(DWORD_W-SRC_CONST_W){1'b0}}, k};
      end else begin
        fill = {1'b0, k[6:0], 24'd0};
      end
      res = {VEC_COMPS{fill}};
    end else begin
      for (c = 0; c < VEC_COMPS; c++) begin
        sel = int'(sw[2*c +: 2]);
        res[DWORD_W*c +: DWORD_W] = v[DWORD_W*sel +: DWORD_W];
      end
    end
    return res;
  endfunction

  // ==================================================
  // Stimulus file
  // ==================================================
  task automatic load_stimulus(output logic ok);
    int         fd;
    int         code;
    int         need;
    int         k;
    logic       done;
    logic [7:0] kind_tok;
    logic [8*128-1:0] line_buf;
    name_t      t_name;
    reg_addr_t  t_addr;
    src_op_t    t_op;
    swz4d_t     t_swz;
    src_const_t t_cnst;
    vec4_t      t_wdata;
    vec4_t      t_exp;
    ok = 1'b1;
    done = 1'b0;
    num_recs = 0;
    fd = $fopen("sim/operand_fetch_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      ok = 1'b0;
      done = 1'b1;
    end
    while (!done) begin
      code = $fscanf(fd, "%s", kind_tok);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind_tok == "#") begin
        // Rest of a comment line
        code = $fgets(line_buf, fd);
      end else if (num_recs >= MAX_RECS) begin
        $display("Stimulus file holds more records than the testbench can store");
        ok = 1'b0;
        done = 1'b1;
      end else begin
        t_name = "-";
        t_addr = '0;
        t_op = '0;
        t_swz = SWZ_IDENTITY;
        t_cnst = '0;
        t_wdata = '0;
        t_exp = '0;
        need = 0;
        code = 0;
        case (kind_tok)
          "W": begin
            need = 2;
            code = $fscanf(fd, "%h %h", t_addr, t_wdata);
          end
          "X": begin
            need = 1;
            code = $fscanf(fd, "%h", t_addr);
            for (k = 0; k < VEC_COMPS; k++) begin
              t_wdata[DWORD_W*k +: DWORD_W] = $random(rand_seed);
            end
          end
          "R": begin
            need = 6;
            code = $fscanf(fd, "%s %h %h %h %h %h", t_name, t_addr, t_op, t_swz,
                           t_cnst, t_exp);
          end
          "B": begin
            need = 7;
            code = $fscanf(fd, "%s %h %h %h %h %h %h", t_name, t_addr, t_op, t_swz,
                           t_cnst, t_wdata, t_exp);
          end
          "I": need = 0;
          default: begin
            $display("Unknown record kind %c in the stimulus file", kind_tok);
            ok = 1'b0;
            done = 1'b1;
          end
        endcase
        if (ok && code != need) begin
          $display("Stimulus record %0d has missing fields", num_recs);
          ok = 1'b0;
          done = 1'b1;
        end
        if (ok) begin
          rec_kind[num_recs] = kind_tok;
          rec_name[num_recs] = t_name;
          rec_addr[num_recs] = t_addr;
          rec_op[num_recs] = t_op;
          rec_swz[num_recs] = t_swz;
          rec_cnst[num_recs] = t_cnst;
          rec_wdata[num_recs] = t_wdata;
          rec_exp[num_recs] = t_exp;
          num_recs++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (ok && num_recs == 0) begin
      $display("Stimulus file holds no records");
      ok = 1'b0;
    end
  endtask

  // ==================================================
  // Drive and check
  // ==================================================
  task automatic drive_record(input int n);
    vec4_t pred;
    wr_en = 1'b0;
    rd_en = 1'b0;
    case (rec_kind[n])
      "W", "X": begin
        wr_en = 1'b1;
        wr_addr = rec_addr[n];
        wr_data = rec_wdata[n];
        model_regs[rec_addr[n]] = rec_wdata[n];
      end
      "R", "B": begin
        // Model sees the old entry, as the DUT does on a same-cycle write
        pred = predict_operand(model_regs[rec_addr[n]], rec_op[n], rec_swz[n],
                               rec_cnst[n]);
        if (pred !== rec_exp[n]) begin
          $display("Stimulus record %0s expects %h but the operand rules give %h",
                   rec_name[n], rec_exp[n], pred);
          err_cnt++;
        end
        rd_en = 1'b1;
        rd_addr = rec_addr[n];
        src_op = rec_op[n];
        swz = rec_swz[n];
        src_const = rec_cnst[n];
        pend_name.push_back(rec_name[n]);
        pend_exp.push_back(rec_exp[n]);
        pend_cycle.push_back(tick);
        if (rec_kind[n] == "B") begin
          wr_en = 1'b1;
          wr_addr = rec_addr[n];
          wr_data = rec_wdata[n];
          model_regs[rec_addr[n]] = rec_wdata[n];
        end
      end
      default: begin
        // Idle cycle
      end
    endcase
  endtask

  // Idle outputs since reset, reported once the first operand shows up
  task automatic report_reset_state();
    if (reset_bad) begin
      $display("ERR reset_idle expected %h actual %h", vec4_t'(0), reset_bad_val);
      fail_cnt++;
    end else begin
      $display("PASS reset_idle");
      pass_cnt++;
    end
  endtask

  task automatic check_outputs();
    name_t nm;
    vec4_t ev;
    int    issued;
    if (src_valid === 1'b1) begin
      if (!first_out_seen) begin
        report_reset_state();
      end
      first_out_seen = 1'b1;
      if (pend_exp.size() == 0) begin
        $display("src_valid went high with no read outstanding");
        err_cnt++;
      end else begin
        nm = pend_name.pop_front();
        ev = pend_exp.pop_front();
        issued = pend_cycle.pop_front();
        if (src_data !== ev) begin
          $display("ERR %0s expected %h actual %h", nm, ev, src_data);
          fail_cnt++;
        end else if (tick - issued != READ_LATENCY) begin
          $display("FAIL %0s arrived %0d cycles after rd_en instead of %0d", nm,
                   tick - issued, READ_LATENCY);
          fail_cnt++;
        end else begin
          $display("PASS %0s", nm);
          pass_cnt++;
        end
      end
    end else if (src_valid !== 1'b0) begin
      $display("src_valid is unknown at cycle %0d", tick);
      err_cnt++;
    end else if (!first_out_seen && src_data !== '0 && !reset_bad) begin
      reset_bad = 1'b1;
      reset_bad_val = src_data;
    end
  endtask

  // ==================================================
  // Main sequence and watchdog
  // ==================================================
  initial begin
    logic ok;
    int   i;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    src_op = '0;
    swz = SWZ_IDENTITY;
    src_const = '0;
    rand_seed = 13581;
    tick = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    err_cnt = 0;
    first_out_seen = 1'b0;
    reset_bad = 1'b0;
    reset_bad_val = '0;
    for (i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    load_stimulus(ok);
    if (!ok) begin
      $display("Simulation failed");
      $finish;
    end else begin
      timeout_cycles = 4 * num_recs + 50;
      // First rising edge that sees reset low, then the falling edge after it
      @(posedge clk);
      while (reset !== 1'b0) @(posedge clk);
      @(negedge clk);
      // Sample the last edge's outputs, then drive the next cycle
      for (i = 0; i < num_recs; i++) begin
        check_outputs();
        drive_record(i);
        @(negedge clk);
        tick++;
      end
      wr_en = 1'b0;
      rd_en = 1'b0;
      while (pend_exp.size() > 0) begin
        check_outputs();
        @(negedge clk);
        tick++;
      end
      // A few quiet cycles catch stray valids
      repeat (3) begin
        check_outputs();
        @(negedge clk);
        tick++;
      end
      $display("Tests passed %0d, failed %0d, other errors %0d", pass_cnt, fail_cnt,
               err_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && pass_cnt > 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
      $display("Run timed out after %0d cycles with %0d reads still outstanding",
               cycle_cnt, pend_exp.size());
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset
// 10 ns clock, reset held high over the first two rising edges
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release on a falling edge, clear of the DUT sampling edge
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- src.f
verilog/shader_isa_pkg.sv
verilog/shader_data_pkg.sv
verilog/src_fetch_if.sv
verilog/vec_regfile.sv
verilog/src_swizzle_4d.sv
verilog/operand_fetch.sv
sim/tb_clock_gen.sv
sim/operand_fetch_tb.sv

//--- verilog/operand_fetch.sv
// Operand fetch stage
// Register file read followed by the swizzle stage; rd_en to
// src_valid takes two cycles and reads may issue every cycle
`timescale 1ns/1ns

module operand_fetch
  import shader_isa_pkg::*, shader_data_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Write port
  input  logic       wr_en,
  input  reg_addr_t  wr_addr,
  input  vec4_t      wr_data,
  // Read request
  input  logic       rd_en,
  input  reg_addr_t  rd_addr,
  input  src_op_t    src_op,
  input  swz4d_t     swz,
  input  src_const_t src_const,
  // Source operand out
  output logic       src_valid,
  output vec4_t      src_data
);

  // Stage 1 to stage 2 bundle
  src_fetch_if fetch_bus ();

  vec_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_op    (src_op),
    .rd_swz   (swz),
    .rd_const (src_const),
    .fetch    (fetch_bus.producer)
  );

  src_swizzle_4d u_swizzle (
    .clk       (clk),
    .reset     (reset),
    .fetch     (fetch_bus.consumer),
    .src_valid (src_valid),
    .src_data  (src_data)
  );

endmodule

//--- verilog/shader_data_pkg.sv
// Shader data widths
// Component word, four-component vector and register address
// types shared by the register file and the swizzle stage
package shader_data_pkg;

  // ==================================================
  // Register file geometry
  // ==================================================
  localparam int NUM_REGS   = 16;
  localparam int REG_ADDR_W = $clog2(NUM_REGS);

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ==================================================
  // Data words
  // ==================================================
  localparam int DWORD_W   = 32;
  localparam int VEC_COMPS = 4;

  // One 32-bit component
  typedef logic [DWORD_W-1:0] dword_t;

  // x in 31:0, y in 63:32, z in 95:64, w in 127:96
  typedef logic [VEC_COMPS*DWORD_W-1:0] vec4_t;

endpackage

//--- verilog/shader_isa_pkg.sv
// Shader ISA encodings
// Source opcode bits, component selectors and the 4D swizzle
// field layout used by the source operand stage
package shader_isa_pkg;

  // ==================================================
  // Component selector
  // ==================================================
  typedef logic [1:0] comp_sel_t;

  localparam int        COMP_SEL_W = 2;
  localparam comp_sel_t COMP_X     = 2'd0;
  localparam comp_sel_t COMP_Y     = 2'd1;
  localparam comp_sel_t COMP_Z     = 2'd2;
  localparam comp_sel_t COMP_W     = 2'd3;

  // ==================================================
  // Source opcode
  // ==================================================
  // Bit 0 picks integer constant, bit 1 turns the modifier on
  typedef logic [1:0] src_op_t;

  localparam int SRCOP_INT_BIT = 0;
  localparam int SRCOP_MOD_BIT = 1;

  // ==================================================
  // Swizzle and instruction constant
  // ==================================================
  // Output x in bits 1:0 up to output w in bits 7:6
  typedef logic [4*COMP_SEL_W-1:0] swz4d_t;

  localparam swz4d_t SWZ_IDENTITY = {COMP_W, COMP_Z, COMP_Y, COMP_X};

  localparam int SRC_CONST_W = 13;
  // Low constant bits that land in the float pattern
  localparam int CONST_FLT_W = 7;
  typedef logic [SRC_CONST_W-1:0] src_const_t;

endpackage

//--- verilog/src_fetch_if.sv
// Source fetch bundle
// Carries the fetched register vector together with the opcode,
// swizzle and constant of the read that produced it
`timescale 1ns/1ns

interface src_fetch_if
  import shader_isa_pkg::*, shader_data_pkg::*;
();

  // One operand per cycle with valid high, no stall
  logic       valid;
  vec4_t      data;
  src_op_t    op;
  swz4d_t     swz;
  src_const_t cnst;

  // Register file side
  modport producer (output valid, data, op, swz, cnst);

  // Swizzle stage side
  modport consumer (input valid, data, op, swz, cnst);

endinterface

//--- verilog/src_swizzle_4d.sv
// Source swizzle, 4D
// Reorders the fetched vector components by the swizzle, or replaces
// all four with the instruction constant when the modifier is set;
// the constant is zero-extended as integer or packed as a float
// pattern. Result and valid are registered
`timescale 1ns/1ns

module src_swizzle_4d
  import shader_isa_pkg::*, shader_data_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  src_fetch_if.consumer fetch,
  output logic  src_valid,
  output vec4_t src_data
);

  // Pick one component out of a vector
  function automatic dword_t pick_comp(input vec4_t v, input comp_sel_t sel);
    dword_t c;
    case (sel)
      COMP_X:  c = v[0*DWORD_W +: DWORD_W];
      COMP_Y:  c = v[1*DWORD_W +: DWORD_W];
      COMP_Z:  c = v[2*DWORD_W +: DWORD_W];
      default: c = v[3*DWORD_W +: DWORD_W];
    endcase
    return c;
  endfunction

  // ==================================================
  // Swizzle and modifier
  // ==================================================
  vec4_t  src_swz;
  dword_t src_mod;
  vec4_t  src_next;

  // Output component i uses swizzle field i
  always_comb begin
    for (int i = 0; i < VEC_COMPS; i++) begin
      src_swz[i*DWORD_W +: DWORD_W] =
        pick_comp(fetch.data, fetch.swz[i*COMP_SEL_W +: COMP_SEL_W]);
    end
  end

  // Integer mode zero-extends the constant
  // Float mode keeps sign 0 and puts the low constant bits at the top of the word
  assign src_mod = fetch.op[SRCOP_INT_BIT] ?
                   {{(DWORD_W-SRC_CONST_W){1'b0}}, fetch.cnst} :
                   {1'b0, fetch.cnst[CONST_FLT_W-1:0], {(DWORD_W-1-CONST_FLT_W){1'b0}}};

  // Modifier overrides the swizzle on every component
  assign src_next = fetch.op[SRCOP_MOD_BIT] ? {VEC_COMPS{src_mod}} : src_swz;

  // ==================================================
  // Output register
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      src_valid <= 1'b0;
      src_data  <= '0;
    end else begin
      src_valid <= fetch.valid;
      // Hold last result between operands
      if (fetch.valid) begin
        src_data <= src_next;
      end
    end
  end

endmodule

//--- verilog/vec_regfile.sv
// Vector register file
// Sixteen four-component registers, one synchronous write port and
// one registered read port; the read request fields are carried
// along with the data so the next stage sees one aligned bundle
`timescale 1ns/1ns

module vec_regfile
  import shader_isa_pkg::*, shader_data_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       wr_en,
  input  reg_addr_t  wr_addr,
  input  vec4_t      wr_data,
  input  logic       rd_en,
  input  reg_addr_t  rd_addr,
  input  src_op_t    rd_op,
  input  swz4d_t     rd_swz,
  input  src_const_t rd_const,
  src_fetch_if.producer fetch
);

  // ==================================================
  // Storage
  // ==================================================
  // Contents are undefined until written
  vec4_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // ==================================================
  // Read port
  // ==================================================
  // Valid follows rd_en one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch.valid <= 1'b0;
    end else begin
      fetch.valid <= rd_en;
    end
  end

  // Data and request fields only load on a read
  // Same-cycle write to the read address is not visible here,
  // the old entry is sampled
  always_ff @(posedge clk) begin
    if (rd_en) begin
      fetch.data <= regs[rd_addr];
      fetch.op   <= rd_op;
      fetch.swz  <= rd_swz;
      fetch.cnst <= rd_const;
    end
  end

endmodule
